// File: hw/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0] strobe_t;

    // cpu load/store port
    typedef struct packed {
        logic    valid;
        logic [31:0] addr;
        strobe_t strobe;
        word_t   data;
    } dbus_req_t;

    typedef struct packed {
        logic  addr_ok;
        logic  data_ok;
        word_t data;
    } dbus_resp_t;

    // burst memory bus, len is beats minus one
    typedef struct packed {
        logic       valid;
        logic       is_write;
        logic [31:0] addr;
        logic [7:0] len;
        word_t      data;
    } cbus_req_t;

    typedef struct packed {
        logic  ready;
        logic  last;
        word_t data;
    } cbus_resp_t;

    function automatic word_t byte_mask(input strobe_t strobe);
        word_t mask;
        for (int i = 0; i < 4; i++) begin
            mask[8*i +: 8] = {8{strobe[i]}};
        end
        return mask;
    endfunction

endpackage

`default_nettype wire

// File: hw/plru_tree.sv
`default_nettype none

module plru_tree #(
    parameter int NUM_WAYS = 4,
    localparam int WAY_BITS = $clog2(NUM_WAYS)
) (
    input  logic [NUM_WAYS-2:0] plru_old,
    input  logic [WAY_BITS-1:0] touch_way,
    output logic [NUM_WAYS-2:0] plru_new,
    output logic [WAY_BITS-1:0] victim_way
);

    // heap order, node n has children 2n+1 and 2n+2
    // a zero bit sends the victim search to the left child

    always_comb begin : victim_walk
        int node;
        node = 0;
        victim_way = '0;
        for (int lvl = 0; lvl < WAY_BITS; lvl++) begin
            victim_way[WAY_BITS-1-lvl] = plru_old[node];
            node = 2 * node + 1 + int'(plru_old[node]);
        end
    end

    always_comb begin : touch_walk
        int node;
        logic dir;
        node = 0;
        plru_new = plru_old;
        for (int lvl = 0; lvl < WAY_BITS; lvl++) begin
            dir = touch_way[WAY_BITS-1-lvl];
            // point away from the touched side
            plru_new[node] = ~dir;
            node = 2 * node + 1 + int'(dir);
        end
    end

endmodule

`default_nettype wire

// File: hw/cache_way.sv
`default_nettype none

module cache_way #(
    parameter int NUM_SETS = 16,
    parameter int WORDS_PER_LINE = 4,
    localparam int INDEX_BITS = $clog2(NUM_SETS),
    localparam int OFFSET_BITS = $clog2(WORDS_PER_LINE),
    localparam int TAG_BITS = 32 - INDEX_BITS - OFFSET_BITS - 2
) (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic [INDEX_BITS-1:0]   index,
    input  logic [TAG_BITS-1:0]     tag,
    input  logic [OFFSET_BITS-1:0]  offset,
    input  logic                    cpu_wen,
    input  dcache_pkg::strobe_t     cpu_strobe,
    input  dcache_pkg::word_t       cpu_data,
    input  logic                    fill_en,
    input  logic [OFFSET_BITS-1:0]  fill_index,
    input  dcache_pkg::word_t       fill_data,
    input  logic                    install,
    output logic                    hit,
    output logic                    valid,
    output logic                    dirty,
    output logic [TAG_BITS-1:0]     way_tag,
    output dcache_pkg::word_t       rd_word,
    output dcache_pkg::word_t       fill_rd_word
);
    import dcache_pkg::*;

    logic [NUM_SETS-1:0] valid_q;
    logic [NUM_SETS-1:0] dirty_q;
    logic [TAG_BITS-1:0] tag_q [NUM_SETS];
    word_t               data_q [NUM_SETS][WORDS_PER_LINE];
    word_t               wr_mask;
    word_t               merged;

    assign wr_mask = byte_mask(cpu_strobe);
    assign merged  = (rd_word & ~wr_mask) | (cpu_data & wr_mask);

    // line state
    always_ff @(posedge clk) begin
        if (resetn) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (install) begin
            valid_q[index] <= 1'b1;
            dirty_q[index] <= 1'b0;
        end else if (cpu_wen) begin
            dirty_q[index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (install) begin
            tag_q[index] <= tag;
        end
    end

    // refill beats and cpu stores never overlap, busy blocks stores
    always_ff @(posedge clk) begin
        if (fill_en) begin
            data_q[index][fill_index] <= fill_data;
        end else if (cpu_wen) begin
            data_q[index][offset] <= merged;
        end
    end

    assign valid        = valid_q[index];
    assign dirty        = dirty_q[index];
    assign way_tag      = tag_q[index];
    assign hit          = valid_q[index] && (tag_q[index] == tag);
    assign rd_word      = data_q[index][offset];
    // also serves the writeback beats of a dirty victim
    assign fill_rd_word = data_q[index][fill_index];

endmodule

`default_nettype wire

// File: hw/way_select.sv
`default_nettype none

module way_select #(
    parameter int NUM_WAYS = 4,
    parameter int NUM_SETS = 16,
    parameter int WORDS_PER_LINE = 4,
    localparam int WAY_BITS = $clog2(NUM_WAYS),
    localparam int INDEX_BITS = $clog2(NUM_SETS),
    localparam int TAG_BITS = 32 - INDEX_BITS - $clog2(WORDS_PER_LINE) - 2
) (
    input  logic                               clk,
    input  logic                               resetn,
    input  logic [INDEX_BITS-1:0]              index,
    input  logic [NUM_WAYS-1:0]                hits,
    input  logic [NUM_WAYS-1:0]                valids,
    input  logic [NUM_WAYS-1:0]                dirties,
    input  logic [NUM_WAYS-1:0][TAG_BITS-1:0]  tags,
    input  dcache_pkg::word_t [NUM_WAYS-1:0]   words,
    input  logic                               touch,
    output logic                               hit,
    output logic [WAY_BITS-1:0]                hit_way,
    output dcache_pkg::word_t                  hit_word,
    output logic [WAY_BITS-1:0]                victim_way,
    output logic                               victim_dirty,
    output logic [TAG_BITS-1:0]                victim_tag
);

    logic [NUM_WAYS-2:0] plru_q [NUM_SETS];
    logic [NUM_WAYS-2:0] plru_new;
    logic [WAY_BITS-1:0] plru_victim;

    plru_tree #(
        .NUM_WAYS(NUM_WAYS)
    ) u_plru (
        .plru_old  (plru_q[index]),
        .touch_way (hit_way),
        .plru_new  (plru_new),
        .victim_way(plru_victim)
    );

    always_ff @(posedge clk) begin
        if (resetn) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                plru_q[s] <= '0;
            end
        end else if (touch) begin
            plru_q[index] <= plru_new;
        end
    end

    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (hits[w]) begin
                hit     = 1'b1;
                hit_way = WAY_BITS'(w);
            end
        end
    end

    assign hit_word = words[hit_way];

    // lowest invalid way first, then the tree
    always_comb begin
        victim_way = plru_victim;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (!valids[w]) begin
                victim_way = WAY_BITS'(w);
            end
        end
    end

    assign victim_dirty = valids[victim_way] && dirties[victim_way];
    assign victim_tag   = tags[victim_way];

endmodule

`default_nettype wire

// File: hw/refill_ctrl.sv
`default_nettype none

module refill_ctrl #(
    parameter int NUM_WAYS = 4,
    parameter int NUM_SETS = 16,
    parameter int WORDS_PER_LINE = 4,
    localparam int WAY_BITS = $clog2(NUM_WAYS),
    localparam int INDEX_BITS = $clog2(NUM_SETS),
    localparam int OFFSET_BITS = $clog2(WORDS_PER_LINE),
    localparam int TAG_BITS = 32 - INDEX_BITS - OFFSET_BITS - 2
) (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    miss,
    input  logic [31:0]             req_addr,
    input  logic [WAY_BITS-1:0]     victim_way,
    input  logic                    victim_dirty,
    input  logic [TAG_BITS-1:0]     victim_tag,
    input  dcache_pkg::word_t       wb_word,
    output dcache_pkg::cbus_req_t   creq,
    input  dcache_pkg::cbus_resp_t  cresp,
    output logic [NUM_WAYS-1:0]     fill_en,
    output logic [OFFSET_BITS-1:0]  fill_index,
    output dcache_pkg::word_t       fill_data,
    output logic [NUM_WAYS-1:0]     install,
    output logic                    busy
);

    localparam int LINE_BITS = OFFSET_BITS + 2;
    localparam int TAG_LSB = INDEX_BITS + LINE_BITS;

    typedef enum logic [1:0] {
        IDLE,
        WRITEBACK,
        FETCH
    } state_t;

    state_t                  state_q;
    logic [OFFSET_BITS-1:0]  beat_q;
    logic                    gap_q;
    logic [WAY_BITS-1:0]     way_q;
    logic [TAG_BITS-1:0]     vtag_q;
    logic [TAG_BITS-1:0]     req_tag_q;
    logic [INDEX_BITS-1:0]   index_q;
    logic                    beat_move;

    assign beat_move = creq.valid && cresp.ready;

    always_ff @(posedge clk) begin
        if (resetn) begin
            state_q <= IDLE;
            beat_q  <= '0;
            gap_q   <= 1'b0;
        end else begin
            gap_q <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (miss) begin
                        state_q <= victim_dirty ? WRITEBACK : FETCH;
                        beat_q  <= '0;
                    end
                end
                WRITEBACK: begin
                    if (beat_move) begin
                        beat_q <= beat_q + 1'b1;
                        if (cresp.last) begin
                            state_q <= FETCH;
                            beat_q  <= '0;
                            // one idle bus cycle between the two bursts
                            gap_q   <= 1'b1;
                        end
                    end
                end
                FETCH: begin
                    if (beat_move) begin
                        beat_q <= beat_q + 1'b1;
                        if (cresp.last) begin
                            state_q <= IDLE;
                            beat_q  <= '0;
                        end
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // victim and miss line captured on the way out of idle
    always_ff @(posedge clk) begin
        if (state_q == IDLE && miss) begin
            way_q     <= victim_way;
            vtag_q    <= victim_tag;
            req_tag_q <= req_addr[31:TAG_LSB];
            index_q   <= req_addr[TAG_LSB-1:LINE_BITS];
        end
    end

    always_comb begin
        creq          = '0;
        creq.valid    = (state_q == WRITEBACK) || (state_q == FETCH && !gap_q);
        creq.is_write = (state_q == WRITEBACK);
        creq.addr     = {(state_q == WRITEBACK) ? vtag_q : req_tag_q, index_q,
                         LINE_BITS'(0)};
        creq.len      = 8'(WORDS_PER_LINE - 1);
        creq.data     = wb_word;
    end

    always_comb begin
        fill_en = '0;
        install = '0;
        if (state_q == FETCH && beat_move) begin
            fill_en[way_q] = 1'b1;
            install[way_q] = cresp.last;
        end
    end

    assign fill_index = beat_q;
    assign fill_data  = cresp.data;
    assign busy       = (state_q != IDLE);

endmodule

`default_nettype wire

// File: hw/dcache_top.sv
`default_nettype none

module dcache_top #(
    parameter int NUM_WAYS = 4,
    parameter int NUM_SETS = 16,
    parameter int WORDS_PER_LINE = 4
) (
    input  logic                    clk,
    input  logic                    resetn,
    input  dcache_pkg::dbus_req_t   dreq,
    output dcache_pkg::dbus_resp_t  dresp,
    output dcache_pkg::cbus_req_t   creq,
    input  dcache_pkg::cbus_resp_t  cresp
);
    import dcache_pkg::*;

    localparam int WAY_BITS = $clog2(NUM_WAYS);
    localparam int INDEX_BITS = $clog2(NUM_SETS);
    localparam int OFFSET_BITS = $clog2(WORDS_PER_LINE);
    localparam int LINE_BITS = OFFSET_BITS + 2;
    localparam int TAG_BITS = 32 - INDEX_BITS - LINE_BITS;
    localparam int TAG_LSB = INDEX_BITS + LINE_BITS;

    logic [TAG_BITS-1:0]                req_tag;
    logic [INDEX_BITS-1:0]              req_index;
    logic [OFFSET_BITS-1:0]             req_offset;
    logic [NUM_WAYS-1:0]                hits;
    logic [NUM_WAYS-1:0]                valids;
    logic [NUM_WAYS-1:0]                dirties;
    logic [NUM_WAYS-1:0]                way_wen;
    logic [NUM_WAYS-1:0]                fill_en;
    logic [NUM_WAYS-1:0]                install;
    logic [NUM_WAYS-1:0][TAG_BITS-1:0]  tags;
    word_t [NUM_WAYS-1:0]               words;
    word_t [NUM_WAYS-1:0]               fill_words;
    logic [OFFSET_BITS-1:0]             fill_index;
    word_t                              fill_data;
    word_t                              hit_word;
    word_t                              rdata_q;
    logic                               hit;
    logic [WAY_BITS-1:0]                hit_way;
    logic [WAY_BITS-1:0]                victim_way;
    logic                               victim_dirty;
    logic [TAG_BITS-1:0]                victim_tag;
    logic                               busy;
    logic                               miss;
    logic                               accept;
    logic                               data_ok_q;

    assign req_tag    = dreq.addr[31:TAG_LSB];
    assign req_index  = dreq.addr[TAG_LSB-1:LINE_BITS];
    assign req_offset = dreq.addr[LINE_BITS-1:2];

    assign accept  = dreq.valid && !busy && hit;
    assign miss    = dreq.valid && !busy && !hit;
    // store goes only to the way that hit
    assign way_wen = (accept && |dreq.strobe) ? (NUM_WAYS'(1) << hit_way) : '0;

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        cache_way #(
            .NUM_SETS      (NUM_SETS),
            .WORDS_PER_LINE(WORDS_PER_LINE)
        ) u_way (
            .clk         (clk),
            .resetn      (resetn),
            .index       (req_index),
            .tag         (req_tag),
            .offset      (req_offset),
            .cpu_wen     (way_wen[w]),
            .cpu_strobe  (dreq.strobe),
            .cpu_data    (dreq.data),
            .fill_en     (fill_en[w]),
            .fill_index  (fill_index),
            .fill_data   (fill_data),
            .install     (install[w]),
            .hit         (hits[w]),
            .valid       (valids[w]),
            .dirty       (dirties[w]),
            .way_tag     (tags[w]),
            .rd_word     (words[w]),
            .fill_rd_word(fill_words[w])
        );
    end

    way_select #(
        .NUM_WAYS      (NUM_WAYS),
        .NUM_SETS      (NUM_SETS),
        .WORDS_PER_LINE(WORDS_PER_LINE)
    ) u_select (
        .clk         (clk),
        .resetn      (resetn),
        .index       (req_index),
        .hits        (hits),
        .valids      (valids),
        .dirties     (dirties),
        .tags        (tags),
        .words       (words),
        .touch       (accept),
        .hit         (hit),
        .hit_way     (hit_way),
        .hit_word    (hit_word),
        .victim_way  (victim_way),
        .victim_dirty(victim_dirty),
        .victim_tag  (victim_tag)
    );

    // victim choice is frozen while busy, so it also picks the writeback way
    refill_ctrl #(
        .NUM_WAYS      (NUM_WAYS),
        .NUM_SETS      (NUM_SETS),
        .WORDS_PER_LINE(WORDS_PER_LINE)
    ) u_refill (
        .clk         (clk),
        .resetn      (resetn),
        .miss        (miss),
        .req_addr    (dreq.addr),
        .victim_way  (victim_way),
        .victim_dirty(victim_dirty),
        .victim_tag  (victim_tag),
        .wb_word     (fill_words[victim_way]),
        .creq        (creq),
        .cresp       (cresp),
        .fill_en     (fill_en),
        .fill_index  (fill_index),
        .fill_data   (fill_data),
        .install     (install),
        .busy        (busy)
    );

    always_ff @(posedge clk) begin
        if (resetn) begin
            data_ok_q <= 1'b0;
        end else begin
            data_ok_q <= accept;
        end
    end

    // old word, sampled at the same edge as the store
    always_ff @(posedge clk) begin
        if (accept) begin
            rdata_q <= hit_word;
        end
    end

    always_comb begin
        dresp         = '0;
        dresp.addr_ok = accept;
        dresp.data_ok = data_ok_q;
        dresp.data    = rdata_q;
    end

endmodule

`default_nettype wire

// File: tests/dcache_checker.sv
`default_nettype none

module dcache_checker (
    input logic                   clk,
    input logic                   resetn,
    input dcache_pkg::dbus_req_t  dreq,
    input dcache_pkg::dbus_resp_t dresp,
    input dcache_pkg::cbus_req_t  creq,
    input dcache_pkg::cbus_resp_t cresp
);

    // bus request holds while memory stalls
    creq_hold: assert property (@(posedge clk) disable iff (resetn)
        (creq.valid && !cresp.ready) |=> $stable(creq))
        else $error("creq changed while a beat was stalled");

    data_ok_after_accept: assert property (@(posedge clk) disable iff (resetn)
        dresp.addr_ok |=> dresp.data_ok)
        else $error("data_ok missing one cycle after addr_ok");

    data_ok_needs_accept: assert property (@(posedge clk) disable iff (resetn)
        dresp.data_ok |-> $past(dresp.addr_ok))
        else $error("data_ok without an accepted request");

    addr_ok_needs_valid: assert property (@(posedge clk) disable iff (resetn)
        dresp.addr_ok |-> dreq.valid)
        else $error("addr_ok raised without a valid request");

    creq_idle_in_reset: assert property (@(posedge clk)
        resetn |=> !creq.valid)
        else $error("creq valid right after reset");

endmodule

bind dcache_top dcache_checker u_checker (.*);

`default_nettype wire

// File: tests/dcache_tb.sv
`default_nettype none

module dcache_tb;
    import dcache_pkg::*;

    localparam int LINE_WORDS = 4;
    localparam int MEM_WORDS = 1024;

    typedef struct packed {
        logic        is_write;
        logic [31:0] addr;
        strobe_t     strobe;
        word_t       wdata;
        word_t       exp_word;
    } step_t;

    logic        clk = 1'b0;
    logic        resetn = 1'b1;
    dbus_req_t   dreq = '0;
    dbus_resp_t  dresp;
    cbus_req_t   creq;
    cbus_resp_t  cresp = '0;

    word_t       mem [MEM_WORDS];
    step_t       steps [$];
    string       names [$];
    logic [31:0] wb_expected [$];
    int          table_len = 0;
    logic [31:0] lfsr = 32'h68b6_5220;
    int unsigned beat = 0;
    cbus_req_t   req_seen = '0;

    dcache_top dut (
        .clk   (clk),
        .resetn(resetn),
        .dreq  (dreq),
        .dresp (dresp),
        .creq  (creq),
        .cresp (cresp)
    );

    always #5 clk = ~clk;

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("Mismatch %s: expected %08h actual %08h",
                                name, expected, actual));
        end
    endtask

    task automatic note_writeback(input logic [31:0] addr);
        if (wb_expected.size() == 0) begin
            abort_run("unexpected writeback burst on the memory bus");
        end else begin
            check_value("writeback order", wb_expected.pop_front(), addr);
        end
    endtask

    task automatic add_step(input string name, input logic is_write, input logic [31:0] addr,
                            input strobe_t strobe, input word_t wdata, input word_t exp_word);
        names.push_back(name);
        steps.push_back({is_write, addr, strobe, wdata, exp_word});
    endtask

    // exp_word is the word as it was before the request
    task automatic build_table();
        add_step("cold read 040", 1'b0, 32'h040, 4'h0, 32'h0, 32'h5a5a_0040);
        add_step("partial write 044", 1'b1, 32'h044, 4'b0011, 32'hdead_beef, 32'h5a5a_0044);
        add_step("merged read 044", 1'b0, 32'h044, 4'h0, 32'h0, 32'h5a5a_beef);
        add_step("partial write 048", 1'b1, 32'h048, 4'b1010, 32'h1122_3344, 32'h5a5a_0048);
        add_step("merged read 048", 1'b0, 32'h048, 4'h0, 32'h0, 32'h115a_3348);
        // five lines in set 0
        add_step("fill write 000", 1'b1, 32'h000, 4'hf, 32'hc0de_0000, 32'h5a5a_0000);
        add_step("fill write 100", 1'b1, 32'h100, 4'hf, 32'hc0de_0100, 32'h5a5a_0100);
        add_step("fill write 200", 1'b1, 32'h200, 4'hf, 32'hc0de_0200, 32'h5a5a_0200);
        add_step("fill write 300", 1'b1, 32'h300, 4'hf, 32'hc0de_0300, 32'h5a5a_0300);
        add_step("evict write 400", 1'b1, 32'h400, 4'hf, 32'hc0de_0400, 32'h5a5a_0400);
        add_step("read back 000", 1'b0, 32'h000, 4'h0, 32'h0, 32'hc0de_0000);
        add_step("read back 100", 1'b0, 32'h100, 4'h0, 32'h0, 32'hc0de_0100);
        add_step("read back 200", 1'b0, 32'h200, 4'h0, 32'h0, 32'hc0de_0200);
        add_step("read back 300", 1'b0, 32'h300, 4'h0, 32'h0, 32'hc0de_0300);
        add_step("read back 400", 1'b0, 32'h400, 4'h0, 32'h0, 32'hc0de_0400);
        add_step("refetch read 004", 1'b0, 32'h004, 4'h0, 32'h0, 32'h5a5a_0004);
        // set 8, touched 2 0 3 so way 1 is the victim
        add_step("fill write 080", 1'b1, 32'h080, 4'hf, 32'hd000_0080, 32'h5a5a_0080);
        add_step("fill write 180", 1'b1, 32'h180, 4'hf, 32'hd000_0180, 32'h5a5a_0180);
        add_step("fill write 280", 1'b1, 32'h280, 4'hf, 32'hd000_0280, 32'h5a5a_0280);
        add_step("fill write 380", 1'b1, 32'h380, 4'hf, 32'hd000_0380, 32'h5a5a_0380);
        add_step("touch read 280", 1'b0, 32'h280, 4'h0, 32'h0, 32'hd000_0280);
        add_step("touch read 080", 1'b0, 32'h080, 4'h0, 32'h0, 32'hd000_0080);
        add_step("touch read 380", 1'b0, 32'h380, 4'h0, 32'h0, 32'hd000_0380);
        add_step("victim read 480", 1'b0, 32'h480, 4'h0, 32'h0, 32'h5a5a_0480);
        add_step("refetch read 180", 1'b0, 32'h180, 4'h0, 32'h0, 32'hd000_0180);
        wb_expected = '{32'h000, 32'h200, 32'h300, 32'h400, 32'h100, 32'h180, 32'h280};
    endtask

    // burst memory, beats counted on the falling edge after they move
    always @(negedge clk) begin : memory_model
        logic [31:0] waddr;
        if (cresp.ready) begin
            waddr = (req_seen.addr >> 2) + beat;
            if (req_seen.is_write) begin
                if (beat == 0) begin
                    note_writeback(req_seen.addr);
                end
                mem[waddr[9:0]] = req_seen.data;
            end
            beat = cresp.last ? 0 : beat + 1;
        end
        req_seen = creq;
        cresp = '0;
        if (creq.valid) begin
            check_value("burst length", 32'(LINE_WORDS - 1), 32'(creq.len));
            lfsr = lfsr_next(lfsr);
            waddr = (creq.addr >> 2) + beat;
            cresp.ready = lfsr[0];
            cresp.last = lfsr[0] && (beat == LINE_WORDS - 1);
            cresp.data = mem[waddr[9:0]];
        end
    end

    initial begin : watchdog
        wait (table_len > 0);
        repeat (table_len * 200) @(posedge clk);
        abort_run("timeout: the request table did not complete in time");
    end

    initial begin : main
        step_t op;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = (32'(i) << 2) ^ 32'h5a5a_0000;
        end
        build_table();
        table_len = steps.size();
        repeat (5) @(negedge clk);
        resetn = 1'b0;
        foreach (steps[i]) begin
            op = steps[i];
            dreq.valid = 1'b1;
            dreq.addr = op.addr;
            dreq.strobe = op.is_write ? op.strobe : 4'h0;
            dreq.data = op.wdata;
            do begin
                @(negedge clk);
            end while (!dresp.data_ok);
            check_value(names[i], op.exp_word, dresp.data);
        end
        dreq = '0;
        repeat (4) @(negedge clk);
        if (wb_expected.size() != 0) begin
            abort_run("some expected writeback bursts never appeared on the bus");
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: dcache_sys.f
hw/dcache_pkg.sv
hw/plru_tree.sv
hw/cache_way.sv
hw/way_select.sv
hw/refill_ctrl.sv
hw/dcache_top.sv
tests/dcache_checker.sv
tests/dcache_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module dcache_tb -f dcache_sys.f

output=$(./obj_dir/Vdcache_tb 2>&1) || {
    echo "$output"
    exit 1
}
echo "$output"
echo "$output" | grep -q "RESULT: PASS"
